// File: common/mem_bus_pkg.sv
package mem_bus_pkg;

    // byte wide data memory with an 8 bit address space
    localparam int ADDR_BITS = 8;
    localparam int DATA_BITS = 8;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;

    // one load/store consumer request
    // read and write are levels held until the matching ready rises
    // at most one of them is high
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        // only meaningful with write
        data_t wdata;
    } cons_req_t;

    // request towards the external memory port
    // held stable until mem_ready is seen for one cycle
    typedef struct packed {
        logic  read_valid;
        logic  write_valid;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

endpackage

// File: common/cache_pkg.sv
package cache_pkg;

    // two words per line so a single bit picks the word
    localparam int OFFSET_BITS = 1;
    localparam int WORDS_PER_LINE = 2;

    // word 0 is the even address and word 1 the odd one
    typedef logic [WORDS_PER_LINE-1:0][mem_bus_pkg::DATA_BITS-1:0] line_t;

    // controller states
    typedef enum logic [2:0] {
        // waiting for a granted request
        IDLE,
        // tag compare against the latched address
        LOOKUP,
        // read hit answered from the line
        HIT_REPLY,
        // miss fill of the even word
        FILL_LOW,
        // miss fill of the odd word then reply
        FILL_HIGH,
        // single memory write in flight
        WRITE_THROUGH,
        // ready held until the consumer drops its request
        RELAY
    } ctrl_state_t;

endpackage

// File: logic/consumer_arbiter.sv
`timescale 1ns/100ps

module consumer_arbiter #(
    parameter int NUM_CONSUMERS = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  mem_bus_pkg::cons_req_t  cons_req [NUM_CONSUMERS-1:0],
    output logic [NUM_CONSUMERS-1:0] cons_read_ready,
    output logic [NUM_CONSUMERS-1:0] cons_write_ready,
    output mem_bus_pkg::cons_req_t  sel_req,
    output logic                    sel_valid,
    input  logic                    read_ready,
    input  logic                    write_ready,
    input  logic                    release_grant
);

    localparam int IDX_BITS = (NUM_CONSUMERS > 1) ? $clog2(NUM_CONSUMERS) : 1;

    // grant doubles as the round robin pointer
    logic [IDX_BITS-1:0] grant;
    logic [IDX_BITS-1:0] next_pick;
    logic                busy;
    logic                any_req;

    // search starts one past the consumer served last
    always_comb begin
        int idx;
        next_pick = grant;
        any_req = 1'b0;
        for (int k = 1; k <= NUM_CONSUMERS; k++) begin
            idx = (int'(grant) + k) % NUM_CONSUMERS;
            if (!any_req && (cons_req[idx].read || cons_req[idx].write)) begin
                any_req = 1'b1;
                next_pick = IDX_BITS'(idx);
            end
        end
    end

    // new grant only when idle or in the release cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            grant <= '0;
        end else if (!busy || release_grant) begin
            busy <= any_req;
            if (any_req) begin
                grant <= next_pick;
            end
        end
    end

    assign sel_req = cons_req[grant];
    // masked in the release cycle so the finished request is not seen again
    assign sel_valid = busy && !release_grant && (sel_req.read || sel_req.write);

    // ready levels go to the granted consumer only
    always_comb begin
        cons_read_ready = '0;
        cons_write_ready = '0;
        for (int i = 0; i < NUM_CONSUMERS; i++) begin
            if (busy && grant == IDX_BITS'(i)) begin
                cons_read_ready[i] = read_ready;
                cons_write_ready[i] = write_ready;
            end
        end
    end

    // never more than one consumer answered at a time
    a_one_ready: assert property (@(posedge clk) disable iff (reset)
        $onehot0(cons_read_ready | cons_write_ready));

endmodule

// File: dcache/dcache_store.sv
`timescale 1ns/100ps

module dcache_store #(
    parameter int INDEX_BITS = 4,
    localparam int TAG_BITS = mem_bus_pkg::ADDR_BITS - INDEX_BITS - cache_pkg::OFFSET_BITS
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [INDEX_BITS-1:0] index,
    input  logic [TAG_BITS-1:0] tag,
    output logic                hit,
    output cache_pkg::line_t    line,
    input  logic                fill_word_en,
    input  logic                fill_high,
    input  mem_bus_pkg::data_t  fill_data,
    input  logic                fill_done,
    input  logic                update_en,
    input  logic                update_offset,
    input  mem_bus_pkg::data_t  update_data
);

    localparam int NUM_LINES = 2 ** INDEX_BITS;

    // one valid bit per line
    logic [NUM_LINES-1:0] valid;
    logic [TAG_BITS-1:0]  tags [NUM_LINES-1:0];
    cache_pkg::line_t     lines [NUM_LINES-1:0];

    // combinational lookup on the index
    assign line = lines[index];
    assign hit = valid[index] && (tags[index] == tag);

    // line becomes valid once the odd word has arrived
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (fill_done) begin
            valid[index] <= 1'b1;
        end
    end

    // tag written together with the last fill word
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tags[index] <= tag;
        end
    end

    // word writes from a fill or from a write hit
    always_ff @(posedge clk) begin
        if (fill_word_en) begin
            lines[index][fill_high] <= fill_data;
        end else if (update_en) begin
            lines[index][update_offset] <= update_data;
        end
    end

    // controller never mixes a fill with a write hit
    a_no_fill_update: assert property (@(posedge clk) disable iff (reset)
        !(update_en && (fill_word_en || fill_done)));

endmodule

// File: dcache/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl #(
    parameter int INDEX_BITS = 4,
    localparam int TAG_BITS = mem_bus_pkg::ADDR_BITS - INDEX_BITS - cache_pkg::OFFSET_BITS
) (
    input  logic                   clk,
    input  logic                   reset,
    input  mem_bus_pkg::cons_req_t sel_req,
    input  logic                   sel_valid,
    output logic                   read_ready,
    output logic                   write_ready,
    output mem_bus_pkg::data_t     rdata,
    output logic                   release_grant,
    output logic [INDEX_BITS-1:0]  index,
    output logic [TAG_BITS-1:0]    tag,
    input  logic                   hit,
    input  cache_pkg::line_t       line,
    output logic                   fill_word_en,
    output logic                   fill_high,
    output mem_bus_pkg::data_t     fill_data,
    output logic                   fill_done,
    output logic                   update_en,
    output logic                   update_offset,
    output mem_bus_pkg::data_t     update_data,
    output mem_bus_pkg::mem_req_t  mem_req,
    input  logic                   mem_ready,
    input  mem_bus_pkg::data_t     mem_rdata
);

    cache_pkg::ctrl_state_t state;
    // request captured when leaving IDLE
    mem_bus_pkg::cons_req_t cur_req;
    logic                   offset;
    logic                   mem_done;

    // address = tag | index | offset
    assign offset = cur_req.addr[cache_pkg::OFFSET_BITS-1:0];
    assign index = cur_req.addr[INDEX_BITS+cache_pkg::OFFSET_BITS-1:cache_pkg::OFFSET_BITS];
    assign tag = cur_req.addr[mem_bus_pkg::ADDR_BITS-1:INDEX_BITS+cache_pkg::OFFSET_BITS];

    // memory accepted or answered the pending request
    assign mem_done = mem_ready && (mem_req.read_valid || mem_req.write_valid);

    // store strobes
    assign fill_high = (state == cache_pkg::FILL_HIGH);
    assign fill_word_en = mem_done && mem_req.read_valid &&
                          (state == cache_pkg::FILL_LOW || state == cache_pkg::FILL_HIGH);
    assign fill_done = fill_word_en && fill_high;
    assign fill_data = mem_rdata;
    // write hit patches the cached word while the memory write goes out
    assign update_en = (state == cache_pkg::LOOKUP) && cur_req.write && hit;
    assign update_offset = offset;
    assign update_data = cur_req.wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::IDLE;
            read_ready <= 1'b0;
            write_ready <= 1'b0;
            release_grant <= 1'b0;
            mem_req.read_valid <= 1'b0;
            mem_req.write_valid <= 1'b0;
        end else begin
            release_grant <= 1'b0;
            case (state)
                cache_pkg::IDLE: begin
                    if (sel_valid) begin
                        cur_req <= sel_req;
                        state <= cache_pkg::LOOKUP;
                    end
                end
                cache_pkg::LOOKUP: begin
                    if (cur_req.write) begin
                        // writes go through whether or not they hit
                        mem_req.write_valid <= 1'b1;
                        mem_req.addr <= cur_req.addr;
                        mem_req.wdata <= cur_req.wdata;
                        state <= cache_pkg::WRITE_THROUGH;
                    end else if (hit) begin
                        state <= cache_pkg::HIT_REPLY;
                    end else begin
                        // miss starts with the even word
                        mem_req.read_valid <= 1'b1;
                        mem_req.addr <= {tag, index, {cache_pkg::OFFSET_BITS{1'b0}}};
                        state <= cache_pkg::FILL_LOW;
                    end
                end
                cache_pkg::HIT_REPLY: begin
                    rdata <= line[offset];
                    read_ready <= 1'b1;
                    state <= cache_pkg::RELAY;
                end
                cache_pkg::FILL_LOW: begin
                    // valid drops for a cycle before the odd read
                    if (mem_done) begin
                        mem_req.read_valid <= 1'b0;
                        mem_req.addr <= {tag, index, cache_pkg::OFFSET_BITS'(1)};
                        state <= cache_pkg::FILL_HIGH;
                    end
                end
                cache_pkg::FILL_HIGH: begin
                    if (!mem_req.read_valid) begin
                        mem_req.read_valid <= 1'b1;
                    end else if (mem_done) begin
                        mem_req.read_valid <= 1'b0;
                        // even word already sits in the line
                        rdata <= offset ? mem_rdata : line[0];
                        read_ready <= 1'b1;
                        state <= cache_pkg::RELAY;
                    end
                end
                cache_pkg::WRITE_THROUGH: begin
                    if (mem_done) begin
                        mem_req.write_valid <= 1'b0;
                        write_ready <= 1'b1;
                        state <= cache_pkg::RELAY;
                    end
                end
                cache_pkg::RELAY: begin
                    // consumer saw ready and let go of its request
                    if (!sel_valid) begin
                        read_ready <= 1'b0;
                        write_ready <= 1'b0;
                        release_grant <= 1'b1;
                        state <= cache_pkg::IDLE;
                    end
                end
                default: begin
                    state <= cache_pkg::IDLE;
                end
            endcase
        end
    end

    a_one_mem_valid: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.read_valid && mem_req.write_valid));

    // request frozen while memory holds us off
    a_mem_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_req.read_valid || mem_req.write_valid) && !mem_ready |=> $stable(mem_req));

endmodule

// File: logic/mem_cache_top.sv
`timescale 1ns/100ps

module mem_cache_top #(
    parameter int NUM_CONSUMERS = 4,
    parameter int INDEX_BITS = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  mem_bus_pkg::cons_req_t   cons_req [NUM_CONSUMERS-1:0],
    output logic [NUM_CONSUMERS-1:0] cons_read_ready,
    output logic [NUM_CONSUMERS-1:0] cons_write_ready,
    output mem_bus_pkg::data_t       cons_rdata,
    output mem_bus_pkg::mem_req_t    mem_req,
    input  logic                     mem_ready,
    input  mem_bus_pkg::data_t       mem_rdata
);

    localparam int TAG_BITS = mem_bus_pkg::ADDR_BITS - INDEX_BITS - cache_pkg::OFFSET_BITS;

    // arbiter to controller
    mem_bus_pkg::cons_req_t sel_req;
    logic                   sel_valid;
    logic                   read_ready;
    logic                   write_ready;
    logic                   release_grant;

    // controller to store
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic                  hit;
    cache_pkg::line_t      line;
    logic                  fill_word_en;
    logic                  fill_high;
    mem_bus_pkg::data_t    fill_data;
    logic                  fill_done;
    logic                  update_en;
    logic                  update_offset;
    mem_bus_pkg::data_t    update_data;

    consumer_arbiter #(
        .NUM_CONSUMERS(NUM_CONSUMERS)
    ) u_arbiter (
        .clk(clk), .reset(reset), .cons_req(cons_req),
        .cons_read_ready(cons_read_ready), .cons_write_ready(cons_write_ready),
        .sel_req(sel_req), .sel_valid(sel_valid),
        .read_ready(read_ready), .write_ready(write_ready), .release_grant(release_grant)
    );

    // read data is shared and qualified by the per consumer ready
    dcache_ctrl #(
        .INDEX_BITS(INDEX_BITS)
    ) u_ctrl (
        .clk(clk), .reset(reset), .sel_req(sel_req), .sel_valid(sel_valid),
        .read_ready(read_ready), .write_ready(write_ready), .rdata(cons_rdata),
        .release_grant(release_grant), .index(index), .tag(tag), .hit(hit), .line(line),
        .fill_word_en(fill_word_en), .fill_high(fill_high), .fill_data(fill_data),
        .fill_done(fill_done), .update_en(update_en), .update_offset(update_offset),
        .update_data(update_data), .mem_req(mem_req), .mem_ready(mem_ready),
        .mem_rdata(mem_rdata)
    );

    dcache_store #(
        .INDEX_BITS(INDEX_BITS)
    ) u_store (
        .clk(clk), .reset(reset), .index(index), .tag(tag), .hit(hit), .line(line),
        .fill_word_en(fill_word_en), .fill_high(fill_high), .fill_data(fill_data),
        .fill_done(fill_done), .update_en(update_en), .update_offset(update_offset),
        .update_data(update_data)
    );

endmodule

// File: verification/ext_mem_model.sv
`timescale 1ns/100ps

module ext_mem_model #(
    parameter int MIN_DELAY = 1,
    parameter int MAX_DELAY = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  mem_bus_pkg::mem_req_t mem_req,
    output logic                  mem_ready,
    output mem_bus_pkg::data_t    mem_rdata,
    output int                    read_count,
    output int                    write_count,
    output mem_bus_pkg::addr_t    last_write_addr,
    output mem_bus_pkg::data_t    last_write_data
);

    // full 8 bit address space, loaded by the testbench
    mem_bus_pkg::data_t mem [0:255];
    logic               busy;
    int                 wait_cnt;

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        read_count = 0;
        write_count = 0;
        last_write_addr = '0;
        last_write_data = '0;
        busy = 1'b0;
        wait_cnt = 0;
    end

    always @(posedge clk) begin
        if (reset) begin
            mem_ready <= 1'b0;
            busy <= 1'b0;
            read_count <= 0;
            write_count <= 0;
        end else begin
            mem_ready <= 1'b0;
            // valid is still up in the cycle after ready, so skip that one
            if (!mem_ready) begin
                if (!busy && (mem_req.read_valid || mem_req.write_valid)) begin
                    busy <= 1'b1;
                    wait_cnt <= int'($urandom_range(MAX_DELAY - 1, MIN_DELAY - 1));
                end else if (busy && wait_cnt > 0) begin
                    wait_cnt <= wait_cnt - 1;
                end else if (busy) begin
                    busy <= 1'b0;
                    mem_ready <= 1'b1;
                    if (mem_req.read_valid) begin
                        // read data valid in the ready cycle
                        mem_rdata <= mem[mem_req.addr];
                        read_count <= read_count + 1;
                    end else begin
                        mem[mem_req.addr] <= mem_req.wdata;
                        last_write_addr <= mem_req.addr;
                        last_write_data <= mem_req.wdata;
                        write_count <= write_count + 1;
                    end
                end
            end
        end
    end

endmodule

// File: verification/mem_cache_tb.sv
`timescale 1ns/100ps

module mem_cache_tb;

    localparam int NUM_CONS = 4;
    localparam int INDEX_BITS = 4;
    localparam int RAND_OPS = 24;
    // requests of the directed part
    localparam int DIRECTED_REQS = 9;
    localparam int TOTAL_REQS = DIRECTED_REQS + NUM_CONS * RAND_OPS;
    localparam int TIMEOUT_CYCLES = 200 * TOTAL_REQS + 10;

    logic                   clk;
    logic                   reset;
    mem_bus_pkg::cons_req_t cons_req [NUM_CONS-1:0];
    logic [NUM_CONS-1:0]    cons_read_ready;
    logic [NUM_CONS-1:0]    cons_write_ready;
    mem_bus_pkg::data_t     cons_rdata;
    mem_bus_pkg::mem_req_t  mem_req;
    logic                   mem_ready;
    mem_bus_pkg::data_t     mem_rdata;
    int                     read_count;
    int                     write_count;
    mem_bus_pkg::addr_t     last_write_addr;
    mem_bus_pkg::data_t     last_write_data;

    // expected memory updated in write completion order
    mem_bus_pkg::data_t     shadow [0:255];
    // request each consumer has out until its ready falls
    mem_bus_pkg::cons_req_t pending [NUM_CONS-1:0];
    logic [NUM_CONS-1:0]    req_open;
    logic [NUM_CONS-1:0]    prev_read_ready;
    logic [NUM_CONS-1:0]    prev_write_ready;
    mem_bus_pkg::addr_t     read_log [$];
    int                     reads_before;
    int                     writes_before;

    mem_cache_top #(
        .NUM_CONSUMERS(NUM_CONS),
        .INDEX_BITS(INDEX_BITS)
    ) uut (
        .clk(clk), .reset(reset), .cons_req(cons_req),
        .cons_read_ready(cons_read_ready), .cons_write_ready(cons_write_ready),
        .cons_rdata(cons_rdata), .mem_req(mem_req), .mem_ready(mem_ready),
        .mem_rdata(mem_rdata)
    );

    ext_mem_model mem_model (
        .clk(clk), .reset(reset), .mem_req(mem_req), .mem_ready(mem_ready),
        .mem_rdata(mem_rdata), .read_count(read_count), .write_count(write_count),
        .last_write_addr(last_write_addr), .last_write_data(last_write_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: requests still open after %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    // start pattern mixes every address bit
    function automatic mem_bus_pkg::data_t fill_value(input mem_bus_pkg::addr_t a);
        return (a * 8'd37) ^ 8'h5c ^ {a[0], a[7:1]};
    endfunction

    // a read returns the last completed write or the start pattern
    function automatic mem_bus_pkg::data_t expected_read(input mem_bus_pkg::addr_t a);
        return shadow[a];
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s (got %0h, expected %0h)", $time, msg, actual,
                     expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // one level held request from consumer id until its ready falls again
    task automatic access(input int id, input logic is_write, input mem_bus_pkg::addr_t addr,
                          input mem_bus_pkg::data_t wdata);
        mem_bus_pkg::cons_req_t r;
        r.read = !is_write;
        r.write = is_write;
        r.addr = addr;
        r.wdata = wdata;
        @(negedge clk);
        pending[id] = r;
        req_open[id] = 1'b1;
        cons_req[id] = r;
        @(negedge clk);
        while (!(cons_read_ready[id] || cons_write_ready[id])) @(negedge clk);
        cons_req[id] = '0;
        @(negedge clk);
        while (cons_read_ready[id] || cons_write_ready[id]) @(negedge clk);
        req_open[id] = 1'b0;
    endtask

    // miss fetches even word then odd word of the line
    task automatic check_line_fill(input mem_bus_pkg::addr_t addr);
        check_equal(32'(read_count - reads_before), 32'd2, "memory reads for a line fill");
        check_equal(32'(read_log.size()), 32'd2, "logged reads for a line fill");
        check_equal(32'(read_log[0]), 32'({addr[7:1], 1'b0}), "first fill address");
        check_equal(32'(read_log[1]), 32'({addr[7:1], 1'b1}), "second fill address");
    endtask

    task automatic check_write(input mem_bus_pkg::addr_t addr, input mem_bus_pkg::data_t data);
        check_equal(32'(write_count - writes_before), 32'd1, "memory writes for one store");
        check_equal(32'(last_write_addr), 32'(addr), "write address at memory");
        check_equal(32'(last_write_data), 32'(data), "write data at memory");
        // writes never allocate
        check_equal(32'(read_count - reads_before), 32'd0, "memory read during a write");
    endtask

    task automatic random_traffic(input int id);
        logic               is_write;
        mem_bus_pkg::addr_t addr;
        mem_bus_pkg::data_t wdata;
        for (int n = 0; n < RAND_OPS; n++) begin
            is_write = 1'($urandom_range(0, 1));
            // two tags over all indexes so lines get evicted
            addr = 8'($urandom_range(0, 63));
            wdata = 8'($urandom);
            access(id, is_write, addr, wdata);
            repeat ($urandom_range(0, 3)) @(negedge clk);
        end
    endtask

    // memory read address monitor
    always @(negedge clk) begin
        if (!reset && mem_ready && mem_req.read_valid) begin
            read_log.push_back(mem_req.addr);
        end
    end

    // completion checker sampling the readies at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            check_equal(32'($countones(cons_read_ready | cons_write_ready) <= 1), 32'd1,
                        "ready to more than one consumer");
            for (int i = 0; i < NUM_CONS; i++) begin
                if (cons_read_ready[i] && !prev_read_ready[i]) begin
                    check_equal(32'(req_open[i] && pending[i].read), 32'd1,
                                $sformatf("read ready to consumer %0d without a read", i));
                    check_equal(32'(cons_rdata), 32'(expected_read(pending[i].addr)),
                                $sformatf("consumer %0d read of %02h", i, pending[i].addr));
                end
                if (cons_write_ready[i] && !prev_write_ready[i]) begin
                    check_equal(32'(req_open[i] && pending[i].write), 32'd1,
                                $sformatf("write ready to consumer %0d without a write", i));
                    shadow[pending[i].addr] = pending[i].wdata;
                end
            end
        end
        prev_read_ready = cons_read_ready;
        prev_write_ready = cons_write_ready;
    end

    initial begin
        void'($urandom(32'h8178_36eb));
        reset = 1'b1;
        for (int i = 0; i < NUM_CONS; i++) begin
            cons_req[i] = '0;
            pending[i] = '0;
        end
        req_open = '0;
        prev_read_ready = '0;
        prev_write_ready = '0;
        for (int a = 0; a < 256; a++) begin
            shadow[a] = fill_value(8'(a));
            mem_model.mem[a] = fill_value(8'(a));
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_equal(32'(cons_read_ready | cons_write_ready), 32'd0, "ready after reset");
        check_equal(32'({mem_req.read_valid, mem_req.write_valid}), 32'd0,
                    "memory valid after reset");

        // cold read of tag 1, index 3
        read_log.delete();
        reads_before = read_count;
        access(0, 1'b0, 8'h26, 8'h00);
        check_line_fill(8'h26);
        // both words of that line now hit
        reads_before = read_count;
        access(1, 1'b0, 8'h27, 8'h00);
        access(2, 1'b0, 8'h26, 8'h00);
        check_equal(32'(read_count - reads_before), 32'd0, "memory read on a hit");

        // write hit goes through and patches the line
        writes_before = write_count;
        access(3, 1'b1, 8'h27, 8'ha5);
        check_write(8'h27, 8'ha5);
        access(0, 1'b0, 8'h27, 8'h00);
        check_equal(32'(read_count - reads_before), 32'd0, "memory read after a write hit");
        // write miss leaves the line unallocated
        writes_before = write_count;
        access(1, 1'b1, 8'h50, 8'h3c);
        check_write(8'h50, 8'h3c);
        read_log.delete();
        access(2, 1'b0, 8'h50, 8'h00);
        check_line_fill(8'h50);

        // same index, other tag, then back again
        read_log.delete();
        reads_before = read_count;
        access(3, 1'b0, 8'h66, 8'h00);
        check_line_fill(8'h66);
        read_log.delete();
        reads_before = read_count;
        access(0, 1'b0, 8'h27, 8'h00);
        check_line_fill(8'h27);

        // one process per consumer
        fork
            random_traffic(0);
            random_traffic(1);
            random_traffic(2);
            random_traffic(3);
        join
        repeat (2) @(negedge clk);
        for (int a = 0; a < 256; a++) begin
            check_equal(32'(mem_model.mem[a]), 32'(shadow[a]), $sformatf("memory word %02h", a));
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: mem_cache.f
common/mem_bus_pkg.sv
common/cache_pkg.sv
logic/consumer_arbiter.sv
dcache/dcache_store.sv
dcache/dcache_ctrl.sv
logic/mem_cache_top.sv
verification/ext_mem_model.sv
verification/mem_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mem_cache_tb -f mem_cache.f -o mem_cache_sim \
    && ./obj_dir/mem_cache_sim \
    || exit 1
